//--- Bender.yml
package:
  name: support_logic

sources:
  # synthesizable observation logic
  - target: rtl
    files:
      - rtl/obi_mon_pkg.sv
      - rtl/core_ctrl_pkg.sv
      - rtl/obi_phase_monitor.sv
      - rtl/trap_req_checker.sv
      - rtl/support_logic.sv

  # directed testbench, its task header lives next to it
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_support_logic.sv

//--- build.f
+incdir+testbench
rtl/obi_mon_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/obi_phase_monitor.sv
rtl/trap_req_checker.sv
rtl/support_logic.sv
testbench/tb_support_logic.sv

//--- rtl/core_ctrl_pkg.sv
/*
 * core controller types
 * PC source selection and the controller status seen by the trap checker
 */
package core_ctrl_pkg;

  // --------------------------------------------------
  // PC source
  // --------------------------------------------------
  // selects where the next fetch address comes from when pc_set is high
  // the two trap sources are the ones the trap checker cares about
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_DBE = 3'd5,
    PC_TRAP_IRQ = 3'd6
  } pc_mux_e;

  // --------------------------------------------------
  // controller status
  // --------------------------------------------------
  // pc_set marks the cycle in which the controller redirects the PC
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } ctrl_fsm_t;

endpackage

//--- rtl/obi_mon_pkg.sv
/*
 * OBI observation types
 * describes one observed OBI request/response channel and the
 * phase status that a channel monitor reports for it
 */
package obi_mon_pkg;

  // --------------------------------------------------
  // counter sizing
  // --------------------------------------------------
  // width of the outstanding transaction counter, which saturates at 2**CNT_W - 1
  localparam int unsigned CNT_W = 4;

  // --------------------------------------------------
  // observed channel
  // --------------------------------------------------
  // the four handshake wires of one OBI channel as seen by a monitor
  // address and payload are of no interest here and are left out
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
    logic rready;
  } obi_bus_t;

  // --------------------------------------------------
  // reported status
  // --------------------------------------------------
  // every field is a flop and follows the sampled channel by one cycle
  typedef struct packed {
    // req was high without gnt, so the address phase continues
    logic             addr_ph_cont;
    // rvalid was high without rready, so the response phase continues
    logic             resp_ph_cont;
    // number of granted requests still waiting for their response
    logic [CNT_W-1:0] outstanding;
    // a response completed while nothing was outstanding
    logic             resp_viol;
  } obi_phase_t;

endpackage

//--- rtl/obi_phase_monitor.sv
/*
 * OBI phase monitor
 * watches one OBI channel and reports held address and response
 * phases, the outstanding transaction count and responses that
 * arrive with nothing outstanding, all one cycle after the event
 */
module obi_phase_monitor #(
  parameter int unsigned CNT_W = obi_mon_pkg::CNT_W
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  obi_mon_pkg::obi_bus_t   bus_i,
  output obi_mon_pkg::obi_phase_t phase_o
);

  // --------------------------------------------------
  // parameter check
  // --------------------------------------------------
  // the status struct carries the package counter width, so the two must agree
  if (CNT_W != obi_mon_pkg::CNT_W) begin : g_cnt_w_check
    $error("counter width must match the width of obi_phase_t.outstanding");
  end

  localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

  // --------------------------------------------------
  // phase decode
  // --------------------------------------------------
  logic addr_done;
  logic resp_done;

  // an address phase ends when the request is granted
  assign addr_done = bus_i.req & bus_i.gnt;
  // a response phase ends when the manager takes the response
  assign resp_done = bus_i.rvalid & bus_i.rready;

  // --------------------------------------------------
  // status flops
  // --------------------------------------------------
  logic             addr_ph_cont_q;
  logic             resp_ph_cont_q;
  logic [CNT_W-1:0] cnt_q;
  logic             resp_viol_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_q <= 1'b0;
      resp_ph_cont_q <= 1'b0;
      cnt_q          <= '0;
      resp_viol_q    <= 1'b0;
    end else begin
      // a held phase is a valid side that the other side did not accept
      addr_ph_cont_q <= bus_i.req & ~bus_i.gnt;
      resp_ph_cont_q <= bus_i.rvalid & ~bus_i.rready;

      // both phases ending together leave the count where it is
      if (addr_done && !resp_done) begin
        // stick at the top rather than wrap back to zero
        if (cnt_q != CNT_MAX) begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else if (resp_done && !addr_done) begin
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end

      // only a lone response at zero counts as a violation, and only for one cycle
      resp_viol_q <= resp_done & ~addr_done & (cnt_q == '0);
    end
  end

  assign phase_o.addr_ph_cont = addr_ph_cont_q;
  assign phase_o.resp_ph_cont = resp_ph_cont_q;
  assign phase_o.outstanding  = cnt_q;
  assign phase_o.resp_viol    = resp_viol_q;

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------
  // a full counter must never roll over to zero on the next cycle
  a_no_wrap: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == CNT_MAX) |=> (cnt_q != '0)
  ) else $error("outstanding counter wrapped from maximum to zero");

endmodule

//--- rtl/support_logic.sv
/*
 * bus observation top level
 * one phase monitor per OBI channel and a trap ordering checker on
 * the data channel, which is entry 0 of the channel array
 */
module support_logic #(
  parameter int unsigned NUM_BUS = 5,
  parameter int unsigned CNT_W   = obi_mon_pkg::CNT_W
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // observed channels, entry 0 is the core data channel
  input  obi_mon_pkg::obi_bus_t    bus_i [NUM_BUS],

  // controller status and retirement pulse from the core
  input  core_ctrl_pkg::ctrl_fsm_t ctrl_i,
  input  logic                     retire_i,

  // per channel phase status, same order as bus_i
  output obi_mon_pkg::obi_phase_t  phase_o [NUM_BUS],

  // a data request went out after a trap and before retirement
  output logic                     req_after_trap_o
);

  // --------------------------------------------------
  // channel monitors
  // --------------------------------------------------
  // every channel gets the same monitor and nothing is shared between them
  for (genvar i = 0; i < NUM_BUS; i++) begin : g_mon
    obi_phase_monitor #(
      .CNT_W (CNT_W)
    ) obi_phase_monitor_i (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .bus_i   (bus_i[i]),
      .phase_o (phase_o[i])
    );
  end

  // --------------------------------------------------
  // trap ordering
  // --------------------------------------------------
  // only the data channel matters for trap ordering
  trap_req_checker trap_req_checker_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .data_bus_i       (bus_i[0]),
    .ctrl_i           (ctrl_i),
    .retire_i         (retire_i),
    .req_after_trap_o (req_after_trap_o)
  );

endmodule

//--- rtl/trap_req_checker.sv
/*
 * trap ordering checker
 * flags a data request that follows a granted one after a trap,
 * before the next instruction retires
 */
module trap_req_checker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  obi_mon_pkg::obi_bus_t    data_bus_i,
  input  core_ctrl_pkg::ctrl_fsm_t ctrl_i,
  input  logic                     retire_i,
  output logic                     req_after_trap_o
);

  // --------------------------------------------------
  // trap decode
  // --------------------------------------------------
  logic trap;

  // exceptions and debug entry count as traps, interrupts and jumps do not
  assign trap = ctrl_i.pc_set &&
                ((ctrl_i.pc_mux == core_ctrl_pkg::PC_TRAP_EXC) ||
                 (ctrl_i.pc_mux == core_ctrl_pkg::PC_TRAP_DBE));

  // --------------------------------------------------
  // trap window tracking
  // --------------------------------------------------
  // high from a trap until the next retirement
  logic trap_active_q;
  // the data grant of the previous cycle, so one more cycle of history
  logic gnt_q;
  logic req_after_trap_q;
  logic req_after_gnt;

  // a new request right after a grant means the LSU kept issuing
  assign req_after_gnt = data_bus_i.req & gnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_active_q    <= 1'b0;
      gnt_q            <= 1'b0;
      req_after_trap_q <= 1'b0;
    end else begin
      gnt_q <= data_bus_i.gnt;

      if (trap) begin
        // the trap cycle itself already counts
        trap_active_q <= 1'b1;
        if (req_after_gnt) begin
          req_after_trap_q <= 1'b1;
        end
      end else if (retire_i) begin
        // retirement closes the window and drops any earlier report
        trap_active_q    <= 1'b0;
        req_after_trap_q <= 1'b0;
      end else if (trap_active_q && req_after_gnt) begin
        req_after_trap_q <= 1'b1;
      end
    end
  end

  assign req_after_trap_o = req_after_trap_q;

  // --------------------------------------------------
  // assertions
  // --------------------------------------------------
  // the controller and the retirement port must never agree on the same cycle
  a_trap_not_retire: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(trap && retire_i)
  ) else $error("trap and retirement seen in the same cycle");

endmodule

//--- testbench/tb_checks.svh
/*
 * testbench stimulus, reference model and compare tasks
 * included inside the testbench top, works on its signals directly
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// stimulus
// --------------------------------------------------
// clear the vector that the next apply_cycle drives
task automatic idle_next();
  for (int i = 0; i < NUM_BUS; i++) begin
    nxt_bus[i] = '0;
  end
  nxt_ctrl   = '0;
  nxt_retire = 1'b0;
endtask

// the DUT samples the previous drive on this edge, so the model steps on it first
task automatic apply_cycle();
  @(posedge clk);
  model_step();
  for (int i = 0; i < NUM_BUS; i++) begin
    bus[i] <= nxt_bus[i];
  end
  ctrl   <= nxt_ctrl;
  retire <= nxt_retire;
endtask

task automatic apply_idle();
  idle_next();
  apply_cycle();
endtask

// outputs are flops, so the falling edge sees them settled
task automatic settle();
  @(negedge clk);
endtask

// fill biases toward granted requests, drain toward taken responses
task automatic random_next(input bit fill);
  logic [31:0] r;
  idle_next();
  for (int i = 0; i < NUM_BUS; i++) begin
    r = $random(seed);
    if (fill) begin
      nxt_bus[i].req    = (r[1:0] != 2'b00);
      nxt_bus[i].gnt    = (r[3:2] != 2'b00);
      nxt_bus[i].rvalid = (r[6:4] == 3'b000);
    end else begin
      nxt_bus[i].req    = (r[2:0] == 3'b000);
      nxt_bus[i].gnt    = r[3];
      nxt_bus[i].rvalid = (r[5:4] != 2'b00);
    end
    nxt_bus[i].rready = (r[8:7] != 2'b00);
  end
endtask

// --------------------------------------------------
// reference model
// --------------------------------------------------
// counts follow the OBI completion rules, the trap window follows the controller
task automatic model_step();
  logic addr_hit;
  logic resp_hit;
  logic trap_seen;
  logic req_gnt;
  for (int i = 0; i < NUM_BUS; i++) begin
    addr_hit = bus[i].req && bus[i].gnt;
    resp_hit = bus[i].rvalid && bus[i].rready;
    exp_phase[i].addr_ph_cont = bus[i].req && !bus[i].gnt;
    exp_phase[i].resp_ph_cont = bus[i].rvalid && !bus[i].rready;
    exp_phase[i].resp_viol    = resp_hit && !addr_hit && (exp_cnt[i] == 0);
    if (addr_hit && !resp_hit && exp_cnt[i] < CNT_MAX) begin
      exp_cnt[i] = exp_cnt[i] + 1;
    end
    if (resp_hit && !addr_hit && exp_cnt[i] > 0) begin
      exp_cnt[i] = exp_cnt[i] - 1;
    end
    exp_phase[i].outstanding = exp_cnt[i][CNT_W-1:0];
  end

  trap_seen = ctrl.pc_set &&
              (ctrl.pc_mux inside {core_ctrl_pkg::PC_TRAP_EXC, core_ctrl_pkg::PC_TRAP_DBE});
  req_gnt   = bus[0].req && model_prev_gnt;
  if (trap_seen) begin
    model_trap_active = 1'b1;
    if (req_gnt) exp_flag = 1'b1;
  end else if (retire) begin
    model_trap_active = 1'b0;
    exp_flag          = 1'b0;
  end else if (model_trap_active && req_gnt) begin
    exp_flag = 1'b1;
  end
  model_prev_gnt = bus[0].gnt;
endtask

// --------------------------------------------------
// compare tasks
// --------------------------------------------------
task automatic check_phase(input obi_mon_pkg::obi_phase_t got,
                           input obi_mon_pkg::obi_phase_t exp,
                           input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH at %0t: %s phase got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

// every channel and the trap flag against the model
task automatic check_against_model();
  for (int i = 0; i < NUM_BUS; i++) begin
    check_phase(phase[i], exp_phase[i], $sformatf("channel %0d", i));
  end
  check_flag(req_after_trap, exp_flag, "req_after_trap");
endtask

`endif

//--- testbench/tb_support_logic.sv
/*
 * bus observation testbench
 * directed tests and seeded random traffic on five OBI channels,
 * checked against a model of the outstanding counts and trap window
 */
module tb_support_logic;

  localparam int NUM_BUS        = 5;
  localparam int CNT_W          = obi_mon_pkg::CNT_W;
  localparam int CNT_MAX        = (1 << CNT_W) - 1;
  localparam int RAND_CYCLES    = 100;
  // reset, directed tests and both random phases, rounded up
  localparam int TEST_CYCLES    = 300;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                     clk;
  logic                     rst_n;
  obi_mon_pkg::obi_bus_t    bus [NUM_BUS];
  core_ctrl_pkg::ctrl_fsm_t ctrl;
  logic                     retire;
  obi_mon_pkg::obi_phase_t  phase [NUM_BUS];
  logic                     req_after_trap;

  // vector for the next drive, filled by the tests
  obi_mon_pkg::obi_bus_t    nxt_bus [NUM_BUS];
  core_ctrl_pkg::ctrl_fsm_t nxt_ctrl;
  logic                     nxt_retire;

  // model state
  obi_mon_pkg::obi_phase_t  exp_phase [NUM_BUS];
  int                       exp_cnt [NUM_BUS];
  logic                     exp_flag;
  logic                     model_trap_active;
  logic                     model_prev_gnt;

  int seed      = 80316;
  int errors    = 0;
  int checks    = 0;
  int cycle_cnt = 0;

  `include "tb_checks.svh"

  support_logic #(
    .NUM_BUS (NUM_BUS),
    .CNT_W   (CNT_W)
  ) support_logic_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .bus_i            (bus),
    .ctrl_i           (ctrl),
    .retire_i         (retire),
    .phase_o          (phase),
    .req_after_trap_o (req_after_trap)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    settle();
    for (int i = 0; i < NUM_BUS; i++) begin
      check_phase(phase[i], '0, $sformatf("reset channel %0d", i));
    end
    check_flag(req_after_trap, 1'b0, "reset req_after_trap");
  endtask

  // a held phase on one channel shows up on that channel alone
  task automatic test_held_phases();
    obi_mon_pkg::obi_phase_t exp;
    for (int kind = 0; kind < 2; kind++) begin
      for (int ch = 0; ch < NUM_BUS; ch++) begin
        idle_next();
        if (kind == 0) nxt_bus[ch].req = 1'b1;
        else nxt_bus[ch].rvalid = 1'b1;
        apply_cycle();
        apply_idle();
        settle();
        for (int i = 0; i < NUM_BUS; i++) begin
          exp = '0;
          exp.addr_ph_cont = (kind == 0) && (i == ch);
          exp.resp_ph_cont = (kind == 1) && (i == ch);
          check_phase(phase[i], exp, $sformatf("held kind %0d on %0d, channel %0d", kind, ch, i));
        end
      end
    end
  endtask

  // a lone response at zero flags for exactly one cycle
  task automatic test_resp_at_zero();
    obi_mon_pkg::obi_phase_t exp;
    idle_next();
    nxt_bus[2].rvalid = 1'b1;
    nxt_bus[2].rready = 1'b1;
    apply_cycle();
    apply_idle();
    settle();
    exp = '0;
    exp.resp_viol = 1'b1;
    check_phase(phase[2], exp, "response at zero");
    apply_idle();
    settle();
    check_phase(phase[2], '0, "cycle after response at zero");
  endtask

  // two back to back granted requests, so the second follows a grant
  task automatic granted_pair();
    for (int k = 0; k < 2; k++) begin
      idle_next();
      nxt_bus[0].req = 1'b1;
      nxt_bus[0].gnt = 1'b1;
      apply_cycle();
    end
    apply_idle();
    settle();
  endtask

  task automatic test_trap_order();
    idle_next();
    nxt_ctrl.pc_set = 1'b1;
    nxt_ctrl.pc_mux = core_ctrl_pkg::PC_TRAP_EXC;
    apply_cycle();
    granted_pair();
    check_flag(req_after_trap, 1'b1, "request after exception trap");

    idle_next();
    nxt_retire = 1'b1;
    apply_cycle();
    apply_idle();
    settle();
    check_flag(req_after_trap, 1'b0, "cleared by retirement");

    // the window is closed now
    granted_pair();
    check_flag(req_after_trap, 1'b0, "request after retirement");

    // a jump is no trap
    idle_next();
    nxt_ctrl.pc_set = 1'b1;
    nxt_ctrl.pc_mux = core_ctrl_pkg::PC_JUMP;
    apply_cycle();
    granted_pair();
    check_flag(req_after_trap, 1'b0, "request after jump");
  endtask

  // fill the counters into saturation, then drain them past zero
  task automatic test_random_traffic();
    bit saturated;
    saturated = 1'b0;
    for (int k = 0; k < 2 * RAND_CYCLES; k++) begin
      random_next(k < RAND_CYCLES);
      apply_cycle();
      settle();
      check_against_model();
      for (int i = 0; i < NUM_BUS; i++) begin
        if (exp_cnt[i] == CNT_MAX) saturated = 1'b1;
      end
    end
    apply_idle();
    settle();
    check_against_model();
    if (!saturated) begin
      errors++;
      $display("random traffic never drove a counter to saturation");
    end
  endtask

  // --------------------------------------------------
  // run control
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("the run timed out after %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    rst_n  = 1'b0;
    ctrl   = '0;
    retire = 1'b0;
    for (int i = 0; i < NUM_BUS; i++) begin
      bus[i]       = '0;
      exp_phase[i] = '0;
      exp_cnt[i]   = 0;
    end
    exp_flag          = 1'b0;
    model_trap_active = 1'b0;
    model_prev_gnt    = 1'b0;
    idle_next();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_held_phases();
    test_resp_at_zero();
    test_trap_order();
    test_random_traffic();

    $display("checks: %0d  mismatches and failures: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
